//--- source/fetch_pkg.sv
package fetch_pkg;

    // Linear address and data widths
    localparam int ADDR_W = 20;
    localparam int WORD_W = 16;

    // Code segment and instruction pointer
    typedef struct packed {
        logic [15:0] cs;
        logic [15:0] ip;
    } far_ptr_t;

    // Instruction bus request, word addressed
    typedef struct packed {
        logic [ADDR_W-1:1] addr;
        logic              access;
    } ibus_req_t;

    // Instruction bus response
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              ack;
    } ibus_rsp_t;

    // Immediate read request from the decoder
    typedef struct packed {
        logic start;
        logic is_8bit;
    } immed_req_t;

endpackage

//--- source/byte_fifo.sv
module byte_fifo #(
    parameter int depth = 6
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       nearly_full
);
    localparam int PTR_W = $clog2(depth);
    localparam int CNT_W = $clog2(depth + 1);

    logic [7:0]       mem [depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Pointer advance, wrapping at a depth that need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty       = (count == '0);
    assign nearly_full = (count >= CNT_W'(depth - 1));
    assign rd_data     = mem[rd_ptr];

    assign do_wr = wr_en & (count != CNT_W'(depth));
    assign do_rd = rd_en & ~empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- source/prefetch_unit.sv
module prefetch_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_new,
    input  fetch_pkg::far_ptr_t  target,
    output fetch_pkg::ibus_req_t ibus_req,
    input  fetch_pkg::ibus_rsp_t ibus_rsp,
    input  logic                 fifo_nearly_full,
    output logic                 fifo_wr_en,
    output logic                 fifo_flush,
    output logic [7:0]           fifo_wr_data
);
    import fetch_pkg::*;

    far_ptr_t          ptr;
    logic              active;
    logic              discard;
    logic              access_q;
    logic [ADDR_W-1:1] addr_q;
    logic              lane_q;
    logic [ADDR_W-1:0] linear;
    logic              ack;
    logic              start;

    // Segment times 16 plus offset
    assign linear = {ptr.cs, 4'h0} + {4'h0, ptr.ip};

    assign ack = access_q & ibus_rsp.ack;

    // Leave room for the byte in flight
    assign start = active & ~access_q & ~fifo_nearly_full & ~load_new;

    assign ibus_req.access = access_q;
    assign ibus_req.addr   = addr_q;

    assign fifo_flush   = load_new;
    assign fifo_wr_en   = ack & ~discard & ~load_new;
    assign fifo_wr_data = lane_q ? ibus_rsp.data[15:8] : ibus_rsp.data[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            access_q <= 1'b0;
            discard  <= 1'b0;
        end else begin
            if (load_new) begin
                active <= 1'b1;
            end

            if (ack) begin
                access_q <= 1'b0;
            end else if (start) begin
                access_q <= 1'b1;
            end

            // Redirect overtook an outstanding access
            if (ack) begin
                discard <= 1'b0;
            end else if (load_new && access_q) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_new) begin
            ptr <= target;
        end else if (ack && !discard) begin
            ptr.ip <= ptr.ip + 16'd1;
        end

        // Address and lane held for the whole access
        if (start) begin
            addr_q <= linear[ADDR_W-1:1];
            lane_q <= linear[0];
        end
    end

endmodule

//--- source/immediate_reader.sv
module immediate_reader (
    input  logic                           clk,
    input  logic                           rst,
    input  fetch_pkg::immed_req_t          immed_req,
    output logic                           busy,
    output logic                           complete,
    output logic [fetch_pkg::WORD_W-1:0]   immediate,
    output logic                           fifo_rd_en,
    input  logic [7:0]                     fifo_rd_data,
    input  logic                           fifo_empty
);
    import fetch_pkg::*;

    logic       is_8bit_q;
    logic       byte_cnt;
    logic [7:0] low_byte;
    logic       pop;
    logic       last;

    assign fifo_rd_en = busy & ~fifo_empty;
    assign pop        = fifo_rd_en;

    // Final byte of the request
    assign last = pop & (is_8bit_q | byte_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            complete <= 1'b0;
            byte_cnt <= 1'b0;
        end else begin
            complete <= last;

            if (immed_req.start && !busy) begin
                busy     <= 1'b1;
                byte_cnt <= 1'b0;
            end else if (last) begin
                busy     <= 1'b0;
                byte_cnt <= 1'b0;
            end else if (pop) begin
                byte_cnt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (immed_req.start && !busy) begin
            is_8bit_q <= immed_req.is_8bit;
        end

        if (pop && !last) begin
            low_byte <= fifo_rd_data;
        end

        // Little endian, 8-bit values zero extended
        if (last) begin
            if (is_8bit_q) begin
                immediate <= {{(WORD_W - 8){1'b0}}, fifo_rd_data};
            end else begin
                immediate <= {fifo_rd_data, low_byte};
            end
        end
    end

endmodule

//--- source/fetch_unit.sv
module fetch_unit #(
    parameter int FIFO_DEPTH = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_new,
    input  fetch_pkg::far_ptr_t           target,
    output fetch_pkg::ibus_req_t          ibus_req,
    input  fetch_pkg::ibus_rsp_t          ibus_rsp,
    input  fetch_pkg::immed_req_t         immed_req,
    output logic                          busy,
    output logic                          complete,
    output logic [fetch_pkg::WORD_W-1:0]  immediate
);
    // Prefetch to FIFO
    logic       fifo_wr_en;
    logic [7:0] fifo_wr_data;
    logic       fifo_flush;
    logic       fifo_nearly_full;

    // FIFO to immediate reader
    logic       fifo_rd_en;
    logic [7:0] fifo_rd_data;
    logic       fifo_empty;

    prefetch_unit u_prefetch (
        .clk              (clk),
        .rst              (rst),
        .load_new         (load_new),
        .target           (target),
        .ibus_req         (ibus_req),
        .ibus_rsp         (ibus_rsp),
        .fifo_nearly_full (fifo_nearly_full),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_flush       (fifo_flush),
        .fifo_wr_data     (fifo_wr_data)
    );

    byte_fifo #(
        .depth (FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .rst         (rst),
        .flush       (fifo_flush),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    immediate_reader u_immed (
        .clk          (clk),
        .rst          (rst),
        .immed_req    (immed_req),
        .busy         (busy),
        .complete     (complete),
        .immediate    (immediate),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty)
    );

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for the first 3 rising edges
    initial begin
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- test/tb_fetch_unit.sv
module tb_fetch_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    localparam int FIFO_DEPTH = 6;
    // Ten times the summed worst case of all tests
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              rst;
    logic              load_new;
    far_ptr_t          target;
    ibus_req_t         ibus_req;
    ibus_rsp_t         ibus_rsp;
    immed_req_t        immed_req;
    logic              busy;
    logic              complete;
    logic [WORD_W-1:0] immediate;

    // Memory model state
    logic              hold_ack;
    logic              ack_pending;
    logic [1:0]        ack_delay;
    logic [31:0]       ack_rng;

    // Next byte expected from the fetch stream
    far_ptr_t          exp_ptr;
    logic [31:0]       width_rng;
    int                cycles = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    fetch_unit #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .load_new  (load_new),
        .target    (target),
        .ibus_req  (ibus_req),
        .ibus_rsp  (ibus_rsp),
        .immed_req (immed_req),
        .busy      (busy),
        .complete  (complete),
        .immediate (immediate)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] model_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]} ^ 8'h5A;
    endfunction

    // Odd byte in the high lane
    function automatic logic [WORD_W-1:0] bus_word(input logic [ADDR_W-1:1] w);
        return {model_byte({w, 1'b1}), model_byte({w, 1'b0})};
    endfunction

    // Segment times 16 plus offset, wrapping at 1 MiB
    function automatic logic [ADDR_W-1:0] linear_of(input far_ptr_t p);
        return p.cs * ADDR_W'(16) + p.ip;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] expected,
                              input logic [WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:1] expected,
                              input ibus_req_t actual);
        if (actual.addr !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual.addr);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Instruction memory with a random ack delay of 0 to 3 cycles
    initial begin
        ibus_rsp    <= '0;
        ack_pending = 1'b0;
        ack_delay   = 2'd0;
        ack_rng     = 32'd56;
        forever begin
            @(posedge clk);
            if (rst) begin
                ibus_rsp    <= '0;
                ack_pending = 1'b0;
            end else if (ibus_rsp.ack) begin
                ibus_rsp.ack <= 1'b0;
            end else if (ibus_req.access && !hold_ack) begin
                if (!ack_pending) begin
                    ack_rng     = xorshift32(ack_rng);
                    ack_delay   = ack_rng[1:0];
                    ack_pending = 1'b1;
                end
                if (ack_delay == 2'd0) begin
                    ibus_rsp.data <= bus_word(ibus_req.addr);
                    ibus_rsp.ack  <= 1'b1;
                    ack_pending   = 1'b0;
                end else begin
                    ack_delay = ack_delay - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_error("Timeout: the run went past its cycle limit");
        end
    end

    task automatic redirect(input far_ptr_t t);
        load_new <= 1'b1;
        target   <= t;
        @(posedge clk);
        load_new <= 1'b0;
        exp_ptr = t;
    endtask

    // Waits for the rising edge of the next access
    task automatic next_access(output ibus_req_t req);
        while (ibus_req.access) @(posedge clk);
        while (!ibus_req.access) @(posedge clk);
        req = ibus_req;
    endtask

    task automatic read_immediate(input string name, input logic is_8bit);
        logic [7:0]        lo;
        logic [7:0]        hi;
        logic [WORD_W-1:0] expected;
        hi = 8'h00;
        lo = model_byte(linear_of(exp_ptr));
        exp_ptr.ip = exp_ptr.ip + 16'd1;
        if (!is_8bit) begin
            hi = model_byte(linear_of(exp_ptr));
            exp_ptr.ip = exp_ptr.ip + 16'd1;
        end
        expected = {hi, lo};
        immed_req <= '{start: 1'b1, is_8bit: is_8bit};
        @(posedge clk);
        immed_req <= '0;
        @(posedge clk);
        check_flag({name, " busy"}, 1'b1, busy);
        while (!complete) @(posedge clk);
        check_word(name, expected, immediate);
    endtask

    task automatic reset_idle();
        int i;
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            check_flag("reset_idle access", 1'b0, ibus_req.access);
            check_flag("reset_idle busy", 1'b0, busy);
            check_flag("reset_idle complete", 1'b0, complete);
        end
    endtask

    task automatic first_addresses();
        far_ptr_t          t;
        far_ptr_t          p;
        ibus_req_t         req;
        logic [ADDR_W-1:0] lin;
        int                i;
        t = '{cs: 16'h1234, ip: 16'h0010};
        redirect(t);
        for (i = 0; i < 4; i++) begin
            next_access(req);
            p    = t;
            p.ip = t.ip + 16'(i);
            lin  = linear_of(p);
            check_addr("first_addresses", lin[ADDR_W-1:1], req);
        end
    endtask

    // Continues the stream started by first_addresses
    task automatic immediate_order();
        read_immediate("immediate_order 16-bit", 1'b0);
        read_immediate("immediate_order 8-bit", 1'b1);
    endtask

    // Odd IP that wraps from 16'hFFFF to 16'h0000
    task automatic wrap_lanes();
        int i;
        redirect('{cs: 16'hF000, ip: 16'hFFF5});
        for (i = 0; i < 20; i++) begin
            width_rng = xorshift32(width_rng);
            read_immediate("wrap_lanes", width_rng[0]);
        end
    endtask

    task automatic back_pressure();
        int   started;
        logic prev;
        int   i;
        redirect('{cs: 16'h0400, ip: 16'h0123});
        started = 0;
        prev    = ibus_req.access;
        for (i = 0; i < 30; i++) begin
            @(posedge clk);
            if (ibus_req.access && !prev) begin
                started++;
            end
            prev = ibus_req.access;
        end
        if (started > FIFO_DEPTH) begin
            stop_with_error("back_pressure: more accesses started than the FIFO can hold");
        end
        for (i = 0; i < 8; i++) begin
            read_immediate("back_pressure", i[0]);
        end
    endtask

    task automatic redirect_discard();
        far_ptr_t          a;
        far_ptr_t          b;
        ibus_req_t         req;
        logic [ADDR_W-1:0] lin;
        a = '{cs: 16'h0100, ip: 16'h0000};
        b = '{cs: 16'h0200, ip: 16'h0007};
        redirect(a);
        while (ibus_req.access) @(posedge clk);
        hold_ack <= 1'b1;
        next_access(req);
        lin = linear_of(a);
        check_addr("redirect_discard held", lin[ADDR_W-1:1], req);
        // Redirect while the access to a is still waiting for its ack
        redirect(b);
        hold_ack <= 1'b0;
        next_access(req);
        lin = linear_of(b);
        check_addr("redirect_discard new", lin[ADDR_W-1:1], req);
        read_immediate("redirect_discard 16-bit", 1'b0);
        read_immediate("redirect_discard 8-bit", 1'b1);
        read_immediate("redirect_discard 16-bit", 1'b0);
    endtask

    initial begin
        load_new  <= 1'b0;
        target    <= '0;
        immed_req <= '0;
        hold_ack  <= 1'b0;
        width_rng = 32'd56;
        exp_ptr   = '0;
        @(posedge clk);
        while (rst !== 1'b0) @(posedge clk);

        reset_idle();
        first_addresses();
        immediate_order();
        wrap_lanes();
        back_pressure();
        redirect_discard();

        $display("test passed");
        $finish;
    end

endmodule

//--- tb.f
source/fetch_pkg.sv
source/byte_fifo.sv
source/prefetch_unit.sv
source/immediate_reader.sv
source/fetch_unit.sv
test/tb_clock.sv
test/tb_fetch_unit.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -f tb.f \
		--top-module tb_fetch_unit --Mdir obj_dir -o sim_fetch
	@out="$$(./obj_dir/sim_fetch)"; echo "$$out"; \
		echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir
